//--- echoPortal.f
+incdir+hw
hw/portalPkg.sv
hw/syncFifo.sv
hw/readChannel.sv
hw/writeChannel.sv
hw/portalCtrl.sv
hw/echoCore.sv
hw/portalTop.sv
sim/portalTop_sva.sv
sim/portalTb.sv

//--- Makefile
TOP = portalTb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f echoPortal.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f echoPortal.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- sim/portalTb.sv
`timescale 1ns/1ps
`include "portal_params.svh"

module portalTb;
  localparam int BUDGET_CYCLES = 2000; // about 60 bus transfers of up to 30 cycles, plus reset.

  logic CLK = 1'b0;
  logic RST_N;
  logic [`ADDR_W-1:0]        readAddr;
  logic [`TAG_W-1:0]         readTag;
  logic                      readReqEn;
  logic                      readReqRdy;
  logic [`DATA_W+`TAG_W-1:0] readData;
  logic                      readDataRdy;
  logic                      readDataEn;
  logic [`ADDR_W-1:0]        writeAddr;
  logic [`TAG_W-1:0]         writeTag;
  logic                      writeReqEn;
  logic                      writeReqRdy;
  logic [`DATA_W-1:0]        writeData;
  logic                      writeDataEn;
  logic                      writeDataRdy;
  logic [`TAG_W-1:0]         writeDone;
  logic                      writeDoneRdy;
  logic                      writeDoneEn;
  logic                      interrupt;

  int checks = 0;
  int errors = 0;
  int failures = 0;
  logic [15:0] lfsr = 16'd2359;

  portalTop u_dut (.*);

  always #5 CLK = ~CLK;

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  function automatic logic [`ADDR_W-1:0] makeAddr(input logic ctrl,
      input portalPkg::portalSel_t sel, input logic [`OFFSET_W-1:0] off);
    return {ctrl, sel, off};
  endfunction

  task automatic randWord(output logic [`DATA_W-1:0] w);
    for (int i = 0; i < `DATA_W; i++) begin
      w[i] = lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
  endtask

  task automatic checkData(input string name, input logic [`DATA_W-1:0] exp,
      input logic [`DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkTag(input string name, input logic [`TAG_W-1:0] exp,
      input logic [`TAG_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected tag %h, actual tag %h", name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // bus tasks start and end on a falling edge.
  task automatic sendRead(input logic [`ADDR_W-1:0] addr, input logic [`TAG_W-1:0] tag);
    while (!readReqRdy) @(negedge CLK);
    readAddr = addr;
    readTag = tag;
    readReqEn = 1'b1;
    @(negedge CLK);
    readReqEn = 1'b0;
  endtask

  task automatic takeRead(output logic [`DATA_W-1:0] data, output logic [`TAG_W-1:0] tag);
    while (!readDataRdy) @(negedge CLK);
    data = readData[`DATA_W+`TAG_W-1:`TAG_W];
    tag = readData[`TAG_W-1:0];
    readDataEn = 1'b1;
    @(negedge CLK);
    readDataEn = 1'b0;
  endtask

  task automatic doRead(input logic [`ADDR_W-1:0] addr, input logic [`TAG_W-1:0] tag,
      output logic [`DATA_W-1:0] data, output logic [`TAG_W-1:0] rtag);
    sendRead(addr, tag);
    takeRead(data, rtag);
  endtask

  task automatic doWrite(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
      input logic [`TAG_W-1:0] tag, output logic [`TAG_W-1:0] done);
    while (!(writeReqRdy && writeDataRdy)) @(negedge CLK);
    writeAddr = addr;
    writeTag = tag;
    writeData = data;
    writeReqEn = 1'b1;
    writeDataEn = 1'b1;
    @(negedge CLK);
    writeReqEn = 1'b0;
    writeDataEn = 1'b0;
    while (!writeDoneRdy) @(negedge CLK);
    done = writeDone;
    writeDoneEn = 1'b1;
    @(negedge CLK);
    writeDoneEn = 1'b0;
  endtask

  task automatic sayOnce(input string name, input logic [`DATA_W-1:0] msg,
      input logic [`TAG_W-1:0] tag);
    logic [`TAG_W-1:0] done;
    doWrite(makeAddr(1'b0, portalPkg::REQ_PORTAL, 5'h00), msg, tag, done);
    checkTag(name, tag, done);
  endtask

  task automatic waitEcho();
    logic [`DATA_W-1:0] data;
    logic [`TAG_W-1:0] tag;
    data = '0;
    while (data != `DATA_W'(1)) begin
      doRead(makeAddr(1'b0, portalPkg::IND_PORTAL, 5'h04), 6'd63, data, tag);
    end
  endtask

  task automatic resetValues();
    checkBit("resetValues", 1'b0, readDataRdy);
    checkBit("resetValues", 1'b0, writeDoneRdy);
    checkBit("resetValues", 1'b0, interrupt);
    checkBit("resetValues", 1'b1, readReqRdy);
    checkBit("resetValues", 1'b1, writeReqRdy);
    checkBit("resetValues", 1'b1, writeDataRdy);
  endtask

  task automatic controlConstants();
    logic [`OFFSET_W-1:0] offs [9] = '{5'h00, 5'h04, 5'h08, 5'h0C, 5'h10, 5'h14, 5'h18, 5'h1C,
                                      5'h03};
    logic [`DATA_W-1:0] exp [9];
    logic [`DATA_W-1:0] data;
    logic [`TAG_W-1:0] tag;
    portalPkg::portalSel_t sel;
    for (int p = 0; p < 2; p++) begin
      sel = (p == 0) ? portalPkg::IND_PORTAL : portalPkg::REQ_PORTAL;
      exp = '{32'd0, 32'd0, 32'd1, 32'd0, (p == 0) ? 32'd5 : 32'd6, 32'd2,
              32'd0, 32'd0, 32'h005A05A0};
      for (int i = 0; i < 9; i++) begin
        doRead(makeAddr(1'b1, sel, offs[i]), `TAG_W'(p * 16 + i), data, tag);
        checkData("controlConstants", exp[i], data);
        checkTag("controlConstants", `TAG_W'(p * 16 + i), tag);
      end
    end
  endtask

  task automatic interruptEnables();
    logic [`DATA_W-1:0] data;
    logic [`TAG_W-1:0] tag;
    logic [`TAG_W-1:0] rtag;
    portalPkg::portalSel_t sel;
    for (int p = 0; p < 2; p++) begin
      sel = (p == 0) ? portalPkg::IND_PORTAL : portalPkg::REQ_PORTAL;
      for (int v = 1; v >= 0; v--) begin
        tag = `TAG_W'(40 + p * 2 + v);
        doWrite(makeAddr(1'b1, sel, portalPkg::REG_INTR_ENABLE), `DATA_W'(v), tag, rtag);
        checkTag("interruptEnables", tag, rtag);
        doRead(makeAddr(1'b1, sel, portalPkg::REG_INTR_ENABLE), tag, data, rtag);
        checkData("interruptEnables", `DATA_W'(v), data);
      end
    end
  endtask

  task automatic echoMessages();
    logic [`DATA_W-1:0] sent [4];
    logic [`DATA_W-1:0] data;
    logic [`TAG_W-1:0] tag;
    for (int i = 0; i < 4; i++) begin
      randWord(sent[i]);
      sayOnce("echoMessages", sent[i], `TAG_W'(48 + i));
    end
    waitEcho();
    for (int i = 0; i < 4; i++) begin
      doRead(makeAddr(1'b0, portalPkg::IND_PORTAL, 5'h00), `TAG_W'(i), data, tag);
      checkData("echoMessages", sent[i], data);
      checkTag("echoMessages", `TAG_W'(i), tag);
    end
    doRead(makeAddr(1'b0, portalPkg::IND_PORTAL, 5'h04), 6'd5, data, tag);
    checkData("echoMessages", `DATA_W'(0), data); // all four echoes consumed.
  endtask

  task automatic interruptLine();
    logic [`DATA_W-1:0] msg;
    logic [`DATA_W-1:0] data;
    logic [`TAG_W-1:0] tag;
    doWrite(makeAddr(1'b1, portalPkg::IND_PORTAL, portalPkg::REG_INTR_ENABLE), 32'd1, 6'd52, tag);
    randWord(msg);
    sayOnce("interruptLine", msg, 6'd53);
    waitEcho();
    checkBit("interruptLine", 1'b1, interrupt);
    doRead(makeAddr(1'b1, portalPkg::IND_PORTAL, portalPkg::REG_CHANNEL), 6'd54, data, tag);
    checkData("interruptLine", `DATA_W'(1), data);
    doRead(makeAddr(1'b1, portalPkg::IND_PORTAL, portalPkg::REG_INTR_STATUS), 6'd55, data, tag);
    checkData("interruptLine", `DATA_W'(1), data);
    doRead(makeAddr(1'b0, portalPkg::IND_PORTAL, 5'h00), 6'd56, data, tag);
    checkData("interruptLine", msg, data);
    checkBit("interruptLine", 1'b0, interrupt);
    // with the enable cleared a pending echo must stay silent.
    doWrite(makeAddr(1'b1, portalPkg::IND_PORTAL, portalPkg::REG_INTR_ENABLE), 32'd0, 6'd57, tag);
    randWord(msg);
    sayOnce("interruptLine", msg, 6'd58);
    waitEcho();
    checkBit("interruptLine", 1'b0, interrupt);
    doRead(makeAddr(1'b0, portalPkg::IND_PORTAL, 5'h00), 6'd59, data, tag);
    checkData("interruptLine", msg, data);
  endtask

  task automatic readBackPressure();
    logic [`DATA_W-1:0] expData [$];
    logic [`TAG_W-1:0] expTag [$];
    logic [`DATA_W-1:0] data;
    logic [`TAG_W-1:0] tag;
    portalPkg::portalSel_t sel;
    int n = 0;
    while (readReqRdy && n < 16) begin
      sel = n[0] ? portalPkg::REQ_PORTAL : portalPkg::IND_PORTAL;
      sendRead(makeAddr(1'b1, sel, portalPkg::REG_ID), `TAG_W'(20 + n));
      expData.push_back(n[0] ? 32'd6 : 32'd5);
      expTag.push_back(`TAG_W'(20 + n));
      n++;
    end
    if (readReqRdy) begin
      failures++;
      $display("readBackPressure: the read request queue never stopped accepting requests");
    end
    while (expData.size() > 0) begin
      takeRead(data, tag);
      checkData("readBackPressure", expData.pop_front(), data);
      checkTag("readBackPressure", expTag.pop_front(), tag);
    end
  endtask

  initial begin
    RST_N = 1'b0;
    readAddr = '0;
    readTag = '0;
    readReqEn = 1'b0;
    readDataEn = 1'b0;
    writeAddr = '0;
    writeTag = '0;
    writeReqEn = 1'b0;
    writeData = '0;
    writeDataEn = 1'b0;
    writeDoneEn = 1'b0;
    repeat (10) @(negedge CLK);
    RST_N = 1'b1;
    @(negedge CLK);
    resetValues();
    controlConstants();
    interruptEnables();
    echoMessages();
    interruptLine();
    readBackPressure();
    $display("checks %0d, value errors %0d, other failures %0d, assertion failures %0d",
             checks, errors, failures, u_dut.u_sva.failCount);
    if (errors + failures + u_dut.u_sva.failCount == 0) $display("test passed");
    else $display("test failed");
    $finish;
  end

  initial begin
    #(BUDGET_CYCLES * 10);
    $display("timeout: the tests did not finish within %0d cycles", BUDGET_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

//--- sim/portalTop_sva.sv
`timescale 1ns/1ps

module portalTop_sva (
  input logic                  CLK,
  input logic                  RST_N,
  input logic                  readReqEn,
  input logic                  readReqRdy,
  input logic                  readDataEn,
  input logic                  readDataRdy,
  input logic                  writeReqEn,
  input logic                  writeReqRdy,
  input logic                  writeDataEn,
  input logic                  writeDataRdy,
  input logic                  writeDoneEn,
  input logic                  writeDoneRdy,
  input logic                  interrupt,
  input logic                  indIntrPending,
  input logic                  ctrlWrEn,
  input portalPkg::portalSel_t ctrlWrPortal,
  input logic                  ctrlWrValue
);
  int failCount = 0;
  logic indEnableSeen;

  // indication enable as last written on the control page.
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indEnableSeen <= 1'b0;
    end else if (ctrlWrEn && ctrlWrPortal == portalPkg::IND_PORTAL) begin
      indEnableSeen <= ctrlWrValue;
    end
  end

  // the response FIFOs come out of reset empty.
  resetIdle: assert property (@(posedge CLK) $rose(RST_N) |-> !readDataRdy && !writeDoneRdy)
    else begin
      $error("a response ready is high in the first cycle after reset");
      failCount++;
    end

  intrPending: assert property (@(posedge CLK) disable iff (!RST_N)
      interrupt |-> indIntrPending && indEnableSeen)
    else begin
      $error("interrupt is high without a pending indication and a set enable");
      failCount++;
    end

  enableWithReady: assert property (@(posedge CLK) disable iff (!RST_N)
      !((readReqEn && !readReqRdy) || (readDataEn && !readDataRdy) ||
        (writeReqEn && !writeReqRdy) || (writeDataEn && !writeDataRdy) ||
        (writeDoneEn && !writeDoneRdy)))
    else begin
      $error("an enable is high while its ready is low");
      failCount++;
    end

endmodule

bind portalTop portalTop_sva u_sva (
  .CLK(CLK), .RST_N(RST_N),
  .readReqEn(readReqEn), .readReqRdy(readReqRdy),
  .readDataEn(readDataEn), .readDataRdy(readDataRdy),
  .writeReqEn(writeReqEn), .writeReqRdy(writeReqRdy),
  .writeDataEn(writeDataEn), .writeDataRdy(writeDataRdy),
  .writeDoneEn(writeDoneEn), .writeDoneRdy(writeDoneRdy),
  .interrupt(interrupt), .indIntrPending(indIntrPending),
  .ctrlWrEn(ctrlWrEn), .ctrlWrPortal(ctrlWrPortal), .ctrlWrValue(ctrlWrValue)
);

//--- hw/portalTop.sv
`timescale 1ns/1ps
`include "portal_params.svh"

module portalTop (
  input  logic                      CLK,
  input  logic                      RST_N,
  input  logic [`ADDR_W-1:0]        readAddr,
  input  logic [`TAG_W-1:0]         readTag,
  input  logic                      readReqEn,
  output logic                      readReqRdy,
  output logic [`DATA_W+`TAG_W-1:0] readData,
  output logic                      readDataRdy,
  input  logic                      readDataEn,
  input  logic [`ADDR_W-1:0]        writeAddr,
  input  logic [`TAG_W-1:0]         writeTag,
  input  logic                      writeReqEn,
  output logic                      writeReqRdy,
  input  logic [`DATA_W-1:0]        writeData,
  input  logic                      writeDataEn,
  output logic                      writeDataRdy,
  output logic [`TAG_W-1:0]         writeDone,
  output logic                      writeDoneRdy,
  input  logic                      writeDoneEn,
  output logic                      interrupt
);
  portalPkg::portalSel_t ctrlRdPortal;
  portalPkg::ctrlReg_t   ctrlRdOffset;
  logic [`DATA_W-1:0]    ctrlRdValue;
  logic                  ctrlWrEn;
  portalPkg::portalSel_t ctrlWrPortal;
  logic                  ctrlWrValue;
  logic                  sayEn;
  logic [`DATA_W-1:0]    sayValue;
  logic                  reqNotFull;
  logic                  indDeq;
  logic [`DATA_W-1:0]    indData;
  logic                  indNotEmpty;
  logic                  indIntrPending;

  readChannel u_read (
    .CLK(CLK), .RST_N(RST_N),
    .readAddr(readAddr), .readTag(readTag), .readReqEn(readReqEn), .readReqRdy(readReqRdy),
    .readData(readData), .readDataRdy(readDataRdy), .readDataEn(readDataEn),
    .ctrlRdPortal(ctrlRdPortal), .ctrlRdOffset(ctrlRdOffset), .ctrlRdValue(ctrlRdValue),
    .indData(indData), .indNotEmpty(indNotEmpty), .indDeq(indDeq), .reqNotFull(reqNotFull)
  );

  writeChannel u_write (
    .CLK(CLK), .RST_N(RST_N),
    .writeAddr(writeAddr), .writeTag(writeTag), .writeReqEn(writeReqEn),
    .writeReqRdy(writeReqRdy), .writeData(writeData), .writeDataEn(writeDataEn),
    .writeDataRdy(writeDataRdy), .writeDone(writeDone), .writeDoneRdy(writeDoneRdy),
    .writeDoneEn(writeDoneEn), .ctrlWrEn(ctrlWrEn), .ctrlWrPortal(ctrlWrPortal),
    .ctrlWrValue(ctrlWrValue), .sayEn(sayEn), .sayValue(sayValue), .reqNotFull(reqNotFull)
  );

  portalCtrl u_ctrl (
    .CLK(CLK), .RST_N(RST_N),
    .ctrlWrEn(ctrlWrEn), .ctrlWrPortal(ctrlWrPortal), .ctrlWrValue(ctrlWrValue),
    .ctrlRdPortal(ctrlRdPortal), .ctrlRdOffset(ctrlRdOffset), .ctrlRdValue(ctrlRdValue),
    .indIntrPending(indIntrPending), .interrupt(interrupt)
  );

  echoCore u_echo (
    .CLK(CLK), .RST_N(RST_N),
    .sayEn(sayEn), .sayValue(sayValue), .reqNotFull(reqNotFull),
    .indDeq(indDeq), .indData(indData), .indNotEmpty(indNotEmpty),
    .indIntrPending(indIntrPending)
  );

endmodule

//--- hw/echoCore.sv
`timescale 1ns/1ps
`include "portal_params.svh"

module echoCore (
  input  logic               CLK,
  input  logic               RST_N,
  input  logic               sayEn,
  input  logic [`DATA_W-1:0] sayValue,
  output logic               reqNotFull,
  input  logic               indDeq,
  output logic [`DATA_W-1:0] indData,
  output logic               indNotEmpty,
  output logic               indIntrPending
);
  logic [`DATA_W-1:0] reqHead;
  logic               reqNotEmpty;
  logic               delayNotFull;
  logic               move;

  // incoming say messages land here first.
  syncFifo #(.WIDTH(`DATA_W), .DEPTH(`REQ_DEPTH)) reqFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .din(sayValue),
    .enq(sayEn),
    .deq(move),
    .dout(reqHead),
    .fullN(reqNotFull),
    .emptyN(reqNotEmpty)
  );

  // each message is heard back unchanged, one per cycle while there is room.
  assign move = reqNotEmpty && delayNotFull;

  syncFifo #(.WIDTH(`DATA_W), .DEPTH(`ECHO_DEPTH)) delayFifo (
    .CLK(CLK),
    .RST_N(RST_N),
    .din(reqHead),
    .enq(move),
    .deq(indDeq),
    .dout(indData),
    .fullN(delayNotFull),
    .emptyN(indNotEmpty)
  );

  assign indIntrPending = indNotEmpty; // an echo waiting is the only interrupt source.

endmodule

//--- hw/portalCtrl.sv
`timescale 1ns/1ps
`include "portal_params.svh"

module portalCtrl (
  input  logic                  CLK,
  input  logic                  RST_N,
  input  logic                  ctrlWrEn,
  input  portalPkg::portalSel_t ctrlWrPortal,
  input  logic                  ctrlWrValue,
  input  portalPkg::portalSel_t ctrlRdPortal,
  input  portalPkg::ctrlReg_t   ctrlRdOffset,
  output logic [`DATA_W-1:0]    ctrlRdValue,
  input  logic                  indIntrPending,
  output logic                  interrupt
);
  logic indEnable;
  logic reqEnable;
  logic pending;
  logic enable;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indEnable <= 1'b0;
      reqEnable <= 1'b0;
    end else if (ctrlWrEn) begin
      if (ctrlWrPortal == portalPkg::IND_PORTAL) indEnable <= ctrlWrValue;
      else reqEnable <= ctrlWrValue;
    end
  end

  // the request portal has nothing to signal, so its status stays 0.
  assign pending = (ctrlRdPortal == portalPkg::IND_PORTAL) ? indIntrPending : 1'b0;
  assign enable = (ctrlRdPortal == portalPkg::IND_PORTAL) ? indEnable : reqEnable;

  always_comb begin
    case (ctrlRdOffset)
      portalPkg::REG_INTR_STATUS: ctrlRdValue = {{(`DATA_W-1){1'b0}}, pending};
      portalPkg::REG_INTR_ENABLE: ctrlRdValue = {{(`DATA_W-1){1'b0}}, enable};
      portalPkg::REG_ONE:         ctrlRdValue = `DATA_W'(1);
      portalPkg::REG_CHANNEL:     ctrlRdValue = {{(`DATA_W-1){1'b0}}, pending}; // channel 0 plus 1.
      portalPkg::REG_ID: begin
        ctrlRdValue = (ctrlRdPortal == portalPkg::IND_PORTAL) ? `IND_PORTAL_ID : `REQ_PORTAL_ID;
      end
      portalPkg::REG_TWO:         ctrlRdValue = `DATA_W'(2);
      5'h18, 5'h1C:               ctrlRdValue = '0;
      default:                    ctrlRdValue = `UNUSED_REG_VALUE;
    endcase
  end

  assign interrupt = indIntrPending && indEnable;

endmodule

//--- hw/writeChannel.sv
`timescale 1ns/1ps
`include "portal_params.svh"

module writeChannel (
  input  logic                  CLK,
  input  logic                  RST_N,
  input  logic [`ADDR_W-1:0]    writeAddr,
  input  logic [`TAG_W-1:0]     writeTag,
  input  logic                  writeReqEn,
  output logic                  writeReqRdy,
  input  logic [`DATA_W-1:0]    writeData,
  input  logic                  writeDataEn,
  output logic                  writeDataRdy,
  output logic [`TAG_W-1:0]     writeDone,
  output logic                  writeDoneRdy,
  input  logic                  writeDoneEn,
  output logic                  ctrlWrEn,
  output portalPkg::portalSel_t ctrlWrPortal,
  output logic                  ctrlWrValue,
  output logic                  sayEn,
  output logic [`DATA_W-1:0]    sayValue,
  input  logic                  reqNotFull
);
  localparam int REQ_W = `ADDR_W + `TAG_W;

  logic [REQ_W-1:0]    reqHead;
  logic                reqEmptyN;
  logic                dataEmptyN;
  logic                doneFullN;
  logic                isCtrl;
  logic                needReq;
  logic                fire;
  portalPkg::ctrlReg_t offset;

  syncFifo #(.WIDTH(REQ_W), .DEPTH(`REQ_DEPTH)) reqFifo (
    .CLK(CLK), .RST_N(RST_N),
    .din({writeAddr, writeTag}), .enq(writeReqEn), .deq(fire),
    .dout(reqHead), .fullN(writeReqRdy), .emptyN(reqEmptyN)
  );

  syncFifo #(.WIDTH(`DATA_W), .DEPTH(`REQ_DEPTH)) dataFifo (
    .CLK(CLK), .RST_N(RST_N),
    .din(writeData), .enq(writeDataEn), .deq(fire),
    .dout(sayValue), .fullN(writeDataRdy), .emptyN(dataEmptyN)
  );

  assign isCtrl = reqHead[REQ_W-1];
  assign ctrlWrPortal = portalPkg::portalSel_t'(reqHead[REQ_W-2]);
  assign offset = portalPkg::ctrlReg_t'(reqHead[`TAG_W +: `OFFSET_W]);
  assign needReq = !isCtrl && ctrlWrPortal == portalPkg::REQ_PORTAL;

  // a say message stalls here until the echo core has room for it.
  assign fire = reqEmptyN && dataEmptyN && doneFullN && (!needReq || reqNotFull);
  assign ctrlWrEn = fire && isCtrl && offset == portalPkg::REG_INTR_ENABLE;
  assign ctrlWrValue = sayValue[0];
  assign sayEn = fire && needReq;

  syncFifo #(.WIDTH(`TAG_W), .DEPTH(`REQ_DEPTH)) doneFifo (
    .CLK(CLK), .RST_N(RST_N),
    .din(reqHead[`TAG_W-1:0]), .enq(fire), .deq(writeDoneEn),
    .dout(writeDone), .fullN(doneFullN), .emptyN(writeDoneRdy)
  );

endmodule

//--- hw/readChannel.sv
`timescale 1ns/1ps
`include "portal_params.svh"

module readChannel (
  input  logic                       CLK,
  input  logic                       RST_N,
  input  logic [`ADDR_W-1:0]         readAddr,
  input  logic [`TAG_W-1:0]          readTag,
  input  logic                       readReqEn,
  output logic                       readReqRdy,
  output logic [`DATA_W+`TAG_W-1:0]  readData,
  output logic                       readDataRdy,
  input  logic                       readDataEn,
  output portalPkg::portalSel_t      ctrlRdPortal,
  output portalPkg::ctrlReg_t        ctrlRdOffset,
  input  logic [`DATA_W-1:0]         ctrlRdValue,
  input  logic [`DATA_W-1:0]         indData,
  input  logic                       indNotEmpty,
  output logic                       indDeq,
  input  logic                       reqNotFull
);
  localparam int REQ_W = `ADDR_W + `TAG_W;

  logic [REQ_W-1:0]   reqHead;
  logic               reqEmptyN;
  logic               dataFullN;
  logic               isCtrl;
  logic               needInd;
  logic               fire;
  logic [`TAG_W-1:0]  headTag;
  logic [`DATA_W-1:0] value;

  syncFifo #(.WIDTH(REQ_W), .DEPTH(`REQ_DEPTH)) reqQueue (
    .CLK(CLK), .RST_N(RST_N),
    .din({readAddr, readTag}), .enq(readReqEn), .deq(fire),
    .dout(reqHead), .fullN(readReqRdy), .emptyN(reqEmptyN)
  );

  assign isCtrl = reqHead[REQ_W-1]; // address bit 6.
  assign ctrlRdPortal = portalPkg::portalSel_t'(reqHead[REQ_W-2]);
  assign ctrlRdOffset = portalPkg::ctrlReg_t'(reqHead[`TAG_W +: `OFFSET_W]);
  assign headTag = reqHead[`TAG_W-1:0];

  // only the indication data register has to wait for a message.
  assign needInd = !isCtrl && ctrlRdPortal == portalPkg::IND_PORTAL &&
                   ctrlRdOffset == portalPkg::REG_INTR_STATUS;
  assign fire = reqEmptyN && dataFullN && (!needInd || indNotEmpty);
  assign indDeq = fire && needInd;

  always_comb begin
    value = '0;
    if (isCtrl) begin
      value = ctrlRdValue;
    end else if (ctrlRdPortal == portalPkg::IND_PORTAL) begin
      if (ctrlRdOffset == portalPkg::REG_INTR_STATUS) value = indData;
      else if (ctrlRdOffset == portalPkg::REG_INTR_ENABLE) value = {{(`DATA_W-1){1'b0}}, indNotEmpty};
    end else if (ctrlRdOffset == portalPkg::REG_INTR_ENABLE) begin
      value = {{(`DATA_W-1){1'b0}}, reqNotFull};
    end
  end

  syncFifo #(.WIDTH(`DATA_W + `TAG_W), .DEPTH(`REQ_DEPTH)) dataFifo (
    .CLK(CLK), .RST_N(RST_N),
    .din({value, headTag}), .enq(fire), .deq(readDataEn),
    .dout(readData), .fullN(dataFullN), .emptyN(readDataRdy)
  );

endmodule

//--- hw/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 2
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic [WIDTH-1:0] din,
  input  logic             enq,
  input  logic             deq,
  output logic [WIDTH-1:0] dout,
  output logic             fullN,
  output logic             emptyN
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [CNT_W-1:0] count;
  logic doEnq;
  logic doDeq;

  // the flags guard both sides, so a request on a full or empty FIFO is dropped.
  assign doEnq = enq && fullN;
  assign doDeq = deq && emptyN;
  assign fullN = count != CNT_W'(DEPTH);
  assign emptyN = count != '0;
  assign dout = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doEnq) wrPtr <= (wrPtr == LAST) ? '0 : wrPtr + 1'b1;
      if (doDeq) rdPtr <= (rdPtr == LAST) ? '0 : rdPtr + 1'b1;
      if (doEnq && !doDeq) count <= count + 1'b1;
      else if (doDeq && !doEnq) count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (doEnq) mem[wrPtr] <= din;
  end

endmodule

//--- hw/portalPkg.sv
`include "portal_params.svh"

package portalPkg;

  // portal select, taken from address bit 5.
  typedef enum logic {
    IND_PORTAL = 1'b0,
    REQ_PORTAL = 1'b1
  } portalSel_t;

  // control page offsets; in data space offset 0 is the data register
  // and offset 4 is the status register.
  typedef enum logic [`OFFSET_W-1:0] {
    REG_INTR_STATUS = 5'h00,
    REG_INTR_ENABLE = 5'h04,
    REG_ONE         = 5'h08,
    REG_CHANNEL     = 5'h0C,
    REG_ID          = 5'h10,
    REG_TWO         = 5'h14
  } ctrlReg_t;

endpackage

//--- hw/portal_params.svh
`ifndef PORTAL_PARAMS_SVH
`define PORTAL_PARAMS_SVH

// address layout is {control bit, portal bit, offset}.
`define OFFSET_W 5
`define ADDR_W 7
`define TAG_W 6
`define DATA_W 32

`define ECHO_DEPTH 8
`define REQ_DEPTH 2

// fixed values seen on the control pages.
`define IND_PORTAL_ID 32'd5
`define REQ_PORTAL_ID 32'd6
`define UNUSED_REG_VALUE 32'h005A05A0

`endif
